// File: Bender.yml
package:
  name: rv_issue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/rv_issue_pkg.sv
      - hw/reg_file.sv
      - hw/operand_bypass.sv
      - hw/load_use_detect.sv
      - hw/operand_select.sv
      - hw/issue_stage_reg.sv
      - hw/rv_issue_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/rv_issue_tb.sv

// File: hw/issue_stage_reg.sv
`include "rv_issue_params.svh"

module issue_stage_reg (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                in_valid,
	input  logic                out_ready,
	input  logic [`XLEN-1:0]    pc,
	input  logic [31:0]         instr,
	input  logic [4:0]          alu_ctrl,
	input  logic                mem_w_en,
	input  logic                wb_sel,
	input  logic                reg_w_en,
	input  logic                branch,
	input  logic [11:0]         br_imm,
	input  logic [`RADDR_W-1:0] rd_sel,
	input  logic [`XLEN-1:0]    src_a_next,
	input  logic [`XLEN-1:0]    src_b_next,
	input  logic [`XLEN-1:0]    store_data_next,
	output logic                out_valid,
	output logic [`XLEN-1:0]    pc_out,
	output logic [31:0]         instr_out,
	output logic [4:0]          alu_ctrl_out,
	output logic                mem_w_en_out,
	output logic                wb_sel_out,
	output logic                reg_w_en_out,
	output logic                branch_out,
	output logic [11:0]         br_imm_out,
	output logic [`RADDR_W-1:0] rd_out,
	output logic [`XLEN-1:0]    src_a,
	output logic [`XLEN-1:0]    src_b,
	output logic [`XLEN-1:0]    store_data
);

	// control fields, bubble zeroes them
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			mem_w_en_out <= 1'b0;
			reg_w_en_out <= 1'b0;
			branch_out   <= 1'b0;
		end else if (out_ready) begin
			out_valid    <= in_valid && !stall;
			mem_w_en_out <= mem_w_en && !stall;
			reg_w_en_out <= reg_w_en && !stall;
			branch_out   <= branch && !stall;
		end
	end

	// payload, held while execute is not ready
	always_ff @(posedge clk) begin
		if (out_ready) begin
			instr_out <= stall ? 32'b0 : instr; // bubble reads as all-zero instr
			if (!stall) begin
				pc_out       <= pc;
				alu_ctrl_out <= alu_ctrl;
				wb_sel_out   <= wb_sel;
				br_imm_out   <= br_imm;
				rd_out       <= rd_sel;
				src_a        <= src_a_next;
				src_b        <= src_b_next;
				store_data   <= store_data_next;
			end
		end
	end

endmodule

// File: hw/load_use_detect.sv
`include "rv_issue_params.svh"

module load_use_detect import rv_issue_pkg::*; (
	input  opcode_t             opcode,
	input  logic [`RADDR_W-1:0] rs1,
	input  logic [`RADDR_W-1:0] rs2,
	input  logic                ex_is_load,
	input  logic                ex_w_en,
	input  logic [`RADDR_W-1:0] ex_rd,
	output logic                stall
);

	logic reads_rs1;
	logic reads_rs2;
	logic load_in_ex;

	// which sources the instruction really consumes
	always_comb begin
		reads_rs1 = 1'b0;
		reads_rs2 = 1'b0;
		case (opcode)
			OP_REG, OP_REG32, OP_STORE, OP_BRANCH: begin
				reads_rs1 = 1'b1;
				reads_rs2 = 1'b1;
			end
			OP_IMM, OP_IMM32, OP_LOAD, OP_JALR: begin
				reads_rs1 = 1'b1;
			end
			default: begin
				reads_rs1 = 1'b0;
				reads_rs2 = 1'b0;
			end
		endcase
	end

	assign load_in_ex = ex_is_load && ex_w_en && ex_rd != '0;

	// load data only exists after mem
	assign stall = load_in_ex &&
		((reads_rs1 && ex_rd == rs1) || (reads_rs2 && ex_rd == rs2));

endmodule

// File: hw/operand_bypass.sv
`include "rv_issue_params.svh"

module operand_bypass import rv_issue_pkg::*; #(
	parameter int DATA_W = `XLEN
) (
	input  logic [`RADDR_W-1:0] src,
	input  logic [DATA_W-1:0]   reg_data,
	input  logic                ex_w_en,
	input  logic [`RADDR_W-1:0] ex_rd,
	input  logic [DATA_W-1:0]   ex_result,
	input  logic                mem_w_en,
	input  logic [`RADDR_W-1:0] mem_rd,
	input  logic [DATA_W-1:0]   mem_data,
	input  logic                wb_w_en,
	input  logic [`RADDR_W-1:0] wb_rd,
	input  logic [DATA_W-1:0]   wb_data,
	output logic [DATA_W-1:0]   value,
	output fwd_src_t            src_tag
);

	logic hit_ex;
	logic hit_mem;
	logic hit_wb;

	assign hit_ex  = ex_w_en && ex_rd == src;
	assign hit_mem = mem_w_en && mem_rd == src;
	assign hit_wb  = wb_w_en && wb_rd == src;

	// newest producer wins
	always_comb begin
		if (src == '0) begin
			value   = '0;
			src_tag = FWD_NONE;
		end else if (hit_ex) begin
			value   = ex_result;
			src_tag = FWD_EX;
		end else if (hit_mem) begin
			value   = mem_data;
			src_tag = FWD_MEM;
		end else if (hit_wb) begin
			value   = wb_data; // also covers write-then-read in one cycle
			src_tag = FWD_WB;
		end else begin
			value   = reg_data;
			src_tag = FWD_NONE;
		end
	end

endmodule

// File: hw/operand_select.sv
`include "rv_issue_params.svh"

module operand_select import rv_issue_pkg::*; (
	input  opcode_t             opcode,
	input  logic [`XLEN-1:0]    pc,
	input  logic [11:0]         imm_i,
	input  logic [11:0]         imm_s,
	input  logic [19:0]         imm_u,
	input  imm_sel_t            imm_sel,
	input  src1_sel_t           src1_sel,
	input  src2_sel_t           src2_sel,
	input  logic                dest_sel,
	input  logic [`RADDR_W-1:0] rd,
	input  logic [`RADDR_W-1:0] rs2,
	input  logic [`XLEN-1:0]    rs1_value,
	input  fwd_src_t            rs1_tag,
	input  logic [`XLEN-1:0]    rs2_value,
	input  fwd_src_t            rs2_tag,
	output logic [`XLEN-1:0]    src_a,
	output logic [`XLEN-1:0]    src_b,
	output logic [`XLEN-1:0]    store_data,
	output logic [`RADDR_W-1:0] rd_sel,
	output logic [`XLEN-1:0]    jump_target
);

	logic [`XLEN-1:0] ext_i;
	logic [`XLEN-1:0] ext_s;
	logic [`XLEN-1:0] ext_u;
	logic [`XLEN-1:0] imm;
	logic             fwd_a_ok;
	logic             fwd_b_ok;
	src1_sel_t        sel_a;
	src2_sel_t        sel_b;

	assign ext_i = {{(`XLEN-12){imm_i[11]}}, imm_i};
	assign ext_s = {{(`XLEN-12){imm_s[11]}}, imm_s};
	assign ext_u = {{(`XLEN-32){imm_u[19]}}, imm_u, 12'b0};

	always_comb begin
		case (imm_sel)
			IMM_I:   imm = ext_i;
			IMM_S:   imm = ext_s;
			IMM_U:   imm = ext_u;
			default: imm = '0;
		endcase
	end

	// u-type and jumps keep the decoder's choice for A
	assign fwd_a_ok = !(opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR});
	assign fwd_b_ok = opcode inside {OP_REG, OP_REG32, OP_BRANCH};

	always_comb begin
		sel_a = src1_sel;
		sel_b = src2_sel;
		if (fwd_a_ok) begin
			case (rs1_tag)
				FWD_EX:  sel_a = S1_EX;
				FWD_MEM: sel_a = S1_MEM;
				FWD_WB:  sel_a = S1_WB;
				default: sel_a = src1_sel;
			endcase
		end
		if (fwd_b_ok) begin
			case (rs2_tag)
				FWD_EX:  sel_b = S2_EX;
				FWD_MEM: sel_b = S2_MEM;
				FWD_WB:  sel_b = S2_WB;
				default: sel_b = src2_sel;
			endcase
		end
	end

	always_comb begin
		case (sel_a)
			S1_REG, S1_EX, S1_MEM, S1_WB: src_a = rs1_value; // already resolved
			S1_PC:   src_a = pc;
			default: src_a = '0;
		endcase
		case (sel_b)
			S2_REG, S2_EX, S2_MEM, S2_WB: src_b = rs2_value;
			S2_IMM:  src_b = imm;
			S2_FOUR: src_b = `XLEN'd4; // link address offset
			default: src_b = '0;
		endcase
	end

	assign store_data  = rs2_value;
	assign rd_sel      = dest_sel ? rs2 : rd;
	assign jump_target = rs1_value + ext_i;

endmodule

// File: hw/reg_file.sv
`include "rv_issue_params.svh"

module reg_file (
	input  logic                clk,
	input  logic                reset,
	input  logic [`RADDR_W-1:0] rs1,
	input  logic [`RADDR_W-1:0] rs2,
	input  logic                w_en,
	input  logic [`RADDR_W-1:0] w_addr,
	input  logic [`XLEN-1:0]    w_data,
	output logic [`XLEN-1:0]    rs1_data,
	output logic [`XLEN-1:0]    rs2_data
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:`NREGS-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (w_en && w_addr != '0) begin
			regs[w_addr] <= w_data;
		end
	end

	// same-cycle write shows up through wb forwarding
	always_comb begin
		rs1_data = '0;
		rs2_data = '0;
		if (rs1 != '0) begin
			rs1_data = regs[rs1];
		end
		if (rs2 != '0) begin
			rs2_data = regs[rs2];
		end
	end

endmodule

// File: hw/rv_issue_pkg.sv
package rv_issue_pkg;

	// operand A source, decoder encoding
	typedef enum logic [2:0] {
		S1_REG  = 3'd0,
		S1_EX   = 3'd1,
		S1_MEM  = 3'd2,
		S1_WB   = 3'd3,
		S1_ZERO = 3'd4,
		S1_PC   = 3'd5
	} src1_sel_t;

	// operand B source
	typedef enum logic [2:0] {
		S2_REG  = 3'd0,
		S2_IMM  = 3'd1,
		S2_EX   = 3'd2,
		S2_MEM  = 3'd3,
		S2_WB   = 3'd4,
		S2_FOUR = 3'd5,
		S2_ZERO = 3'd6
	} src2_sel_t;

	typedef enum logic [1:0] {
		IMM_I = 2'd0,
		IMM_S = 2'd1,
		IMM_U = 2'd2
	} imm_sel_t;

	// rv64 major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP_LOAD   = 7'b000_0011,
		OP_IMM    = 7'b001_0011,
		OP_AUIPC  = 7'b001_0111,
		OP_IMM32  = 7'b001_1011,
		OP_STORE  = 7'b010_0011,
		OP_REG    = 7'b011_0011,
		OP_LUI    = 7'b011_0111,
		OP_REG32  = 7'b011_1011,
		OP_BRANCH = 7'b110_0011,
		OP_JALR   = 7'b110_0111,
		OP_JAL    = 7'b110_1111
	} opcode_t;

	typedef enum logic [1:0] {
		FWD_NONE = 2'd0, // register file or x0
		FWD_EX   = 2'd1,
		FWD_MEM  = 2'd2,
		FWD_WB   = 2'd3
	} fwd_src_t;

endpackage

// File: hw/rv_issue_top.sv
`include "rv_issue_params.svh"

module rv_issue_top import rv_issue_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	output logic                in_ready,
	output logic                out_valid,
	input  logic                out_ready,
	input  logic [`XLEN-1:0]    pc,
	input  logic [31:0]         instr,
	input  opcode_t             opcode,
	input  logic [`RADDR_W-1:0] rs1,
	input  logic [`RADDR_W-1:0] rs2,
	input  logic [`RADDR_W-1:0] rd,
	input  logic [11:0]         imm_i,
	input  logic [11:0]         imm_s,
	input  logic [19:0]         imm_u,
	input  logic [11:0]         br_imm,
	input  imm_sel_t            imm_sel,
	input  src1_sel_t           src1_sel,
	input  src2_sel_t           src2_sel,
	input  logic                dest_sel,
	input  logic [4:0]          alu_ctrl,
	input  logic                mem_wr, // decoded store to data memory
	input  logic                wb_sel,
	input  logic                reg_w_en,
	input  logic                branch,
	input  logic                ex_w_en,
	input  logic [`RADDR_W-1:0] ex_rd,
	input  logic [`XLEN-1:0]    ex_result,
	input  logic                ex_is_load,
	input  logic                mem_w_en,
	input  logic [`RADDR_W-1:0] mem_rd,
	input  logic [`XLEN-1:0]    mem_data,
	input  logic                wb_w_en,
	input  logic [`RADDR_W-1:0] wb_rd,
	input  logic [`XLEN-1:0]    wb_data,
	output logic [`XLEN-1:0]    pc_out,
	output logic [31:0]         instr_out,
	output logic [4:0]          alu_ctrl_out,
	output logic                mem_w_en_out,
	output logic                wb_sel_out,
	output logic                reg_w_en_out,
	output logic                branch_out,
	output logic [11:0]         br_imm_out,
	output logic [`RADDR_W-1:0] rd_out,
	output logic [`XLEN-1:0]    src_a,
	output logic [`XLEN-1:0]    src_b,
	output logic [`XLEN-1:0]    store_data,
	output logic [`XLEN-1:0]    jump_target,
	output logic                flow_change
);

	logic [`XLEN-1:0]    rs1_data;
	logic [`XLEN-1:0]    rs2_data;
	logic [`XLEN-1:0]    rs1_value;
	logic [`XLEN-1:0]    rs2_value;
	fwd_src_t            rs1_tag;
	fwd_src_t            rs2_tag;
	logic                stall;
	logic [`XLEN-1:0]    src_a_next;
	logic [`XLEN-1:0]    src_b_next;
	logic [`XLEN-1:0]    store_data_next;
	logic [`RADDR_W-1:0] rd_sel;

	assign in_ready    = out_ready && !stall;
	assign flow_change = opcode == OP_JALR || opcode == OP_BRANCH; // front end holds fetch

	// writeback group is the write port
	reg_file u_reg_file (
		.*,
		.w_en   (wb_w_en),
		.w_addr (wb_rd),
		.w_data (wb_data)
	);

	operand_bypass #(.DATA_W(`XLEN)) u_bypass_rs1 (
		.*,
		.src      (rs1),
		.reg_data (rs1_data),
		.value    (rs1_value),
		.src_tag  (rs1_tag)
	);

	operand_bypass #(.DATA_W(`XLEN)) u_bypass_rs2 (
		.*,
		.src      (rs2),
		.reg_data (rs2_data),
		.value    (rs2_value),
		.src_tag  (rs2_tag)
	);

	load_use_detect u_load_use (.*);

	operand_select u_operand_select (
		.*,
		.src_a      (src_a_next),
		.src_b      (src_b_next),
		.store_data (store_data_next)
	);

	issue_stage_reg u_stage_reg (
		.*,
		.mem_w_en (mem_wr)
	);

endmodule

// File: include/rv_issue_params.svh
`ifndef RV_ISSUE_PARAMS_SVH
`define RV_ISSUE_PARAMS_SVH

// data and address bus width
`define XLEN 64

// architectural integer registers
`define NREGS 32
`define RADDR_W 5

`endif

// File: rv_issue.f
+incdir+include
hw/rv_issue_pkg.sv
hw/reg_file.sv
hw/operand_bypass.sv
hw/load_use_detect.sv
hw/operand_select.sv
hw/issue_stage_reg.sv
hw/rv_issue_top.sv
tb/rv_issue_tb.sv

// File: tb/rv_issue_tb.sv
`include "rv_issue_params.svh"

module rv_issue_tb import rv_issue_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 16;

	logic clk, reset;
	logic in_valid, in_ready, out_valid, out_ready;
	logic [`XLEN-1:0] pc, pc_out, ex_result, mem_data, wb_data;
	logic [`XLEN-1:0] src_a, src_b, store_data, jump_target;
	logic [31:0] instr, instr_out;
	logic [`RADDR_W-1:0] rs1, rs2, rd, rd_out, ex_rd, mem_rd, wb_rd;
	logic [11:0] imm_i, imm_s, br_imm, br_imm_out;
	logic [19:0] imm_u;
	logic [4:0] alu_ctrl, alu_ctrl_out;
	logic dest_sel, mem_wr, wb_sel, reg_w_en, branch;
	logic ex_w_en, ex_is_load, mem_w_en, wb_w_en;
	logic mem_w_en_out, wb_sel_out, reg_w_en_out, branch_out, flow_change;
	opcode_t opcode;
	imm_sel_t imm_sel;
	src1_sel_t src1_sel;
	src2_sel_t src2_sel;

	logic [31:0] lfsr = 32'ha9895a14;
	logic [`XLEN-1:0] shadow [`NREGS]; // values written through wb
	int errors;
	int tests_passed;
	int tests_failed;
	int test_errors;
	string test_name;

	rv_issue_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[62:0], lfsr_step()};
		end
		return r;
	endfunction

	// low bits read as a two's complement number
	function automatic logic [63:0] sign_extend(input logic [63:0] v, input int bits);
		if (v[bits-1]) begin
			return v - (64'd1 << bits);
		end
		return v;
	endfunction

	task automatic check_value(input string what, input logic [`XLEN-1:0] expected,
		input logic [`XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("Mismatch in %s, %s: expected %h, actual %h",
				test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			$display("%s: passed", test_name);
			tests_passed++;
		end else begin
			$display("%s: failed with %0d errors", test_name, errors - test_errors);
			tests_failed++;
		end
	endtask

	task automatic idle_inputs();
		in_valid = 1'b0;
		out_ready = 1'b1;
		pc = '0;
		instr = '0;
		opcode = OP_IMM;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		imm_i = '0;
		imm_s = '0;
		imm_u = '0;
		br_imm = '0;
		imm_sel = IMM_I;
		src1_sel = S1_REG;
		src2_sel = S2_REG;
		dest_sel = 1'b0;
		alu_ctrl = '0;
		mem_wr = 1'b0;
		wb_sel = 1'b0;
		reg_w_en = 1'b0;
		branch = 1'b0;
		ex_w_en = 1'b0;
		ex_rd = '0;
		ex_result = '0;
		ex_is_load = 1'b0;
		mem_w_en = 1'b0;
		mem_rd = '0;
		mem_data = '0;
		wb_w_en = 1'b0;
		wb_rd = '0;
		wb_data = '0;
	endtask

	task automatic set_decode(input opcode_t op, input logic [4:0] r1, input logic [4:0] r2,
		input logic [4:0] d, input src1_sel_t s1, input src2_sel_t s2, input imm_sel_t is);
		opcode = op;
		rs1 = r1;
		rs2 = r2;
		rd = d;
		src1_sel = s1;
		src2_sel = s2;
		imm_sel = is;
		instr = {7'b0, r2, r1, 3'b0, d, op}; // r-type layout
	endtask

	task automatic write_reg(input logic [`RADDR_W-1:0] addr, input logic [`XLEN-1:0] data);
		wb_w_en = 1'b1;
		wb_rd = addr;
		wb_data = data;
		@(negedge clk);
		wb_w_en = 1'b0;
		if (addr != '0) begin
			shadow[addr] = data;
		end
	endtask

	// returns on the falling edge after the item is registered
	task automatic send_item();
		int cycles;
		in_valid = 1'b1;
		cycles = 0;
		#5;
		while (!in_ready && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			#5;
			cycles++;
		end
		if (!in_ready) begin
			$display("%s: in_ready stayed low for %0d cycles", test_name, WAIT_LIMIT);
			errors++;
		end
		@(negedge clk);
		in_valid = 1'b0;
		cycles = 0;
		while (!out_valid && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!out_valid) begin
			$display("%s: out_valid never rose after the item was accepted", test_name);
			errors++;
		end else begin
			check_value("issue latency", 0, cycles);
		end
	endtask

	task automatic reg_file_rw();
		begin_test("reg_file_rw");
		@(negedge clk);
		idle_inputs();
		check_value("out_valid after reset", 0, out_valid);
		check_value("reg_w_en_out after reset", 0, reg_w_en_out);
		check_value("mem_w_en_out after reset", 0, mem_w_en_out);
		check_value("branch_out after reset", 0, branch_out);
		set_decode(OP_REG, 5'd12, 5'd13, 5'd1, S1_REG, S2_REG, IMM_I);
		send_item();
		check_value("x12 after reset", 0, src_a);
		check_value("x13 after reset", 0, src_b);
		for (int r = 0; r < 8; r++) begin
			write_reg(5'(r), random_bits(64));
		end
		set_decode(OP_REG, 5'd3, 5'd5, 5'd1, S1_REG, S2_REG, IMM_I);
		send_item();
		check_value("x3", shadow[3], src_a);
		check_value("x5", shadow[5], src_b);
		set_decode(OP_REG, 5'd0, 5'd7, 5'd1, S1_REG, S2_REG, IMM_I);
		send_item();
		check_value("x0 after write", 0, src_a);
		check_value("x7", shadow[7], src_b);
		end_test();
	endtask

	task automatic forward_priority();
		logic [`XLEN-1:0] ex_v, mem_v, wb_v;
		begin_test("forward_priority");
		ex_v = random_bits(64);
		mem_v = random_bits(64);
		wb_v = random_bits(64);
		@(negedge clk);
		idle_inputs();
		set_decode(OP_REG, 5'd6, 5'd0, 5'd2, S1_REG, S2_REG, IMM_I);
		ex_w_en = 1'b1;
		ex_rd = 5'd6;
		ex_result = ex_v;
		mem_w_en = 1'b1;
		mem_rd = 5'd6;
		mem_data = mem_v;
		wb_w_en = 1'b1;
		wb_rd = 5'd6;
		wb_data = wb_v;
		send_item();
		check_value("ex over mem and wb", ex_v, src_a);
		ex_w_en = 1'b0;
		send_item();
		check_value("mem over wb", mem_v, src_a);
		mem_w_en = 1'b0;
		send_item();
		check_value("wb over register file", wb_v, src_a);
		wb_w_en = 1'b0;
		send_item();
		check_value("register file after wb write", wb_v, src_a);
		end_test();
	endtask

	task automatic load_use_stall();
		logic [`XLEN-1:0] load_v;
		begin_test("load_use_stall");
		load_v = random_bits(64);
		@(negedge clk);
		idle_inputs();
		set_decode(OP_STORE, 5'd3, 5'd8, 5'd0, S1_REG, S2_IMM, IMM_S);
		imm_s = 12'h010;
		mem_wr = 1'b1;
		reg_w_en = 1'b1; // something for the bubble to clear
		ex_is_load = 1'b1;
		ex_w_en = 1'b1;
		ex_rd = 5'd8;
		in_valid = 1'b1;
		#5;
		check_value("in_ready during stall", 0, in_ready);
		@(negedge clk);
		check_value("out_valid in bubble", 0, out_valid);
		check_value("reg_w_en_out in bubble", 0, reg_w_en_out);
		check_value("mem_w_en_out in bubble", 0, mem_w_en_out);
		check_value("instr_out in bubble", 0, instr_out);
		ex_is_load = 1'b0; // load has moved on to mem
		ex_w_en = 1'b0;
		reg_w_en = 1'b0;
		mem_w_en = 1'b1;
		mem_rd = 5'd8;
		mem_data = load_v;
		send_item();
		check_value("store_data", load_v, store_data);
		check_value("mem_w_en_out", 1, mem_w_en_out);
		check_value("store offset", 64'h10, src_b);
		end_test();
	endtask

	task automatic imm_forms();
		logic [11:0] s_imm;
		logic [19:0] u_imm;
		logic [`XLEN-1:0] pc_v;
		logic [`XLEN-1:0] u_ext;
		begin_test("imm_forms");
		s_imm = 12'(random_bits(12));
		u_imm = 20'(random_bits(20));
		pc_v = random_bits(64);
		u_ext = sign_extend({u_imm, 12'h000}, 32);
		@(negedge clk);
		idle_inputs();
		set_decode(OP_STORE, 5'd3, 5'd5, 5'd0, S1_REG, S2_IMM, IMM_S);
		imm_s = s_imm;
		send_item();
		check_value("S immediate", sign_extend(s_imm, 12), src_b);
		set_decode(OP_LUI, 5'd0, 5'd0, 5'd4, S1_ZERO, S2_IMM, IMM_U);
		imm_u = u_imm;
		send_item();
		check_value("LUI src_a", 0, src_a);
		check_value("LUI immediate", u_ext, src_b);
		set_decode(OP_AUIPC, 5'd0, 5'd0, 5'd4, S1_PC, S2_IMM, IMM_U);
		pc = pc_v;
		send_item();
		check_value("AUIPC pc", pc_v, src_a);
		check_value("AUIPC immediate", u_ext, src_b);
		set_decode(OP_JAL, 5'd0, 5'd14, 5'd1, S1_PC, S2_FOUR, IMM_I);
		send_item();
		check_value("JAL link offset", 4, src_b);
		check_value("rd_out from rd", 1, rd_out);
		dest_sel = 1'b1;
		send_item();
		check_value("rd_out from rs2", 14, rd_out);
		end_test();
	endtask

	task automatic back_pressure();
		logic [`XLEN-1:0] pc_v;
		logic [11:0] br_v;
		int hold;
		begin_test("back_pressure");
		hold = 2 + int'(random_bits(3));
		pc_v = random_bits(64);
		br_v = 12'(random_bits(12));
		@(negedge clk);
		idle_inputs();
		set_decode(OP_BRANCH, 5'd3, 5'd5, 5'd2, S1_REG, S2_REG, IMM_I);
		pc = 64'h1000;
		alu_ctrl = 5'h0c;
		branch = 1'b1;
		br_imm = br_v;
		send_item();
		out_ready = 1'b0;
		set_decode(OP_REG, 5'd5, 5'd3, 5'd2, S1_REG, S2_REG, IMM_I);
		pc = pc_v;
		alu_ctrl = 5'h13;
		branch = 1'b0;
		wb_sel = 1'b1;
		reg_w_en = 1'b1;
		in_valid = 1'b1;
		#5;
		check_value("in_ready under back-pressure", 0, in_ready);
		repeat (hold) begin
			@(negedge clk);
			check_value("held out_valid", 1, out_valid);
			check_value("held src_a", shadow[3], src_a);
			check_value("held src_b", shadow[5], src_b);
			check_value("held pc_out", 64'h1000, pc_out);
			check_value("held branch_out", 1, branch_out);
			check_value("held br_imm_out", br_v, br_imm_out);
			check_value("held alu_ctrl_out", 5'h0c, alu_ctrl_out);
		end
		out_ready = 1'b1;
		send_item();
		check_value("src_a after release", shadow[5], src_a);
		check_value("src_b after release", shadow[3], src_b);
		check_value("pc_out after release", pc_v, pc_out);
		check_value("instr_out after release", instr, instr_out);
		check_value("alu_ctrl_out after release", 5'h13, alu_ctrl_out);
		check_value("wb_sel_out after release", 1, wb_sel_out);
		check_value("reg_w_en_out after release", 1, reg_w_en_out);
		check_value("branch_out after release", 0, branch_out);
		end_test();
	endtask

	task automatic jalr_target();
		logic [`XLEN-1:0] base;
		logic [11:0] off;
		begin_test("jalr_target");
		base = random_bits(64);
		off = 12'(random_bits(12));
		@(negedge clk);
		idle_inputs();
		set_decode(OP_JALR, 5'd9, 5'd0, 5'd1, S1_PC, S2_FOUR, IMM_I);
		imm_i = off;
		mem_w_en = 1'b1;
		mem_rd = 5'd9;
		mem_data = base;
		#5;
		check_value("jump_target", base + sign_extend(off, 12), jump_target);
		check_value("flow_change on JALR", 1, flow_change);
		@(negedge clk);
		opcode = OP_IMM;
		#5;
		check_value("flow_change on OP_IMM", 0, flow_change);
		end_test();
	endtask

	initial begin
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		reset = 1'b1;
		idle_inputs();
		out_ready = 1'b0; // stage register only sees reset until the first test
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		reg_file_rw();
		forward_priority();
		load_use_stall();
		imm_forms();
		back_pressure();
		jalr_target();
		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
